// File: list.f
design/mdu_op_pkg.sv
design/mdu_cfg_pkg.sv
design/multiplier.sv
design/div_ctrl_fsm.sv
design/div_step_counter.sv
design/div_datapath.sv
design/mdu_writeback.sv
design/mdu_top.sv
test/mdu_checker.sv
test/mdu_assertions.sv
test/mdu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the mdu testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 -f list.f --top-module mdu_tb \
  -Mdir "$BUILD" -o mdu_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD/mdu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0

// File: test/mdu_tb.sv
`timescale 1ns/100ps

module mdu_tb;

  localparam int unsigned Xlen        = mdu_cfg_pkg::XLEN_DEFAULT;
  localparam int unsigned TransIdBits = mdu_cfg_pkg::TRANS_ID_BITS_DEFAULT;
  localparam int          NumIds      = 1 << TransIdBits;
  localparam int          NumOps      = 400;
  localparam int          WaitLimit   = 8 * Xlen;
  localparam int          DriveDelay  = 2;
  localparam logic [Xlen-1:0] MinNeg  = {1'b1, {(Xlen-1){1'b0}}};

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   valid_i;
  mdu_op_pkg::mdu_op_e    op_i;
  logic [TransIdBits-1:0] trans_id_i;
  logic [Xlen-1:0]        operand_a_i, operand_b_i;
  logic                   result_valid_o;
  logic [Xlen-1:0]        result_o;
  logic [TransIdBits-1:0] result_trans_id_o;
  logic                   div_credit_o;

  // per-tag issue and completion counts
  // a tag is free once both match
  int issued_cnt [NumIds];
  int done_cnt   [NumIds];
  int credits_used, credits_back, timeouts;
  int chk_errors, chk_pending, chk_checked;

  // 20 ns clock
  always #10 clk_i = ~clk_i;

  mdu_top #(
    .Xlen        (Xlen),
    .TransIdBits (TransIdBits)
  ) dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .valid_i           (valid_i),
    .op_i              (op_i),
    .trans_id_i        (trans_id_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .result_valid_o    (result_valid_o),
    .result_o          (result_o),
    .result_trans_id_o (result_trans_id_o),
    .div_credit_o      (div_credit_o)
  );

  mdu_checker #(
    .Xlen        (Xlen),
    .TransIdBits (TransIdBits)
  ) chk (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .valid_i           (valid_i),
    .op_i              (op_i),
    .trans_id_i        (trans_id_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .result_valid_i    (result_valid_o),
    .result_i          (result_o),
    .result_trans_id_i (result_trans_id_o),
    .div_credit_i      (div_credit_o),
    .err_count_o       (chk_errors),
    .pending_count_o   (chk_pending),
    .checked_count_o   (chk_checked)
  );

  bind mdu_top mdu_assertions #(
    .Xlen (Xlen)
  ) i_mdu_assertions (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .result_valid_i (result_valid_o),
    .div_credit_i   (div_credit_o),
    .div_state_i    (i_div_ctrl_fsm.state_q)
  );

  // completions and returned credits sampled mid-cycle
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      credits_back = 0;
      for (int t = 0; t < NumIds; t++) begin
        done_cnt[t] = 0;
      end
    end else begin
      if (result_valid_o) begin
        done_cnt[result_trans_id_o]++;
      end
      if (div_credit_o) begin
        credits_back++;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus helpers
  // ---------------------------------------------------------------------------
  task automatic next_slot();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  function automatic logic has_credit();
    return (int'(mdu_cfg_pkg::DIV_CREDITS) + credits_back - credits_used) > 0;
  endfunction

  // random start so tags get reused in varied order
  function automatic int find_free_tag();
    int start;
    int t;
    start = int'($urandom % NumIds);
    for (int k = 0; k < NumIds; k++) begin
      t = (start + k) % NumIds;
      if (issued_cnt[t] == done_cnt[t]) begin
        return t;
      end
    end
    return -1;
  endfunction

  // corner values show up about half the time
  function automatic logic [Xlen-1:0] pick_operand();
    logic [63:0] raw;
    raw = {$urandom(), $urandom()};
    case ($urandom % 8)
      0:       return '0;
      1:       return '1;
      2:       return {1'b1, {(Xlen-1){1'b0}}};
      3:       return Xlen'($urandom % 16);
      default: return raw[Xlen-1:0];
    endcase
  endfunction

  function automatic mdu_op_pkg::mdu_op_e pick_mul_op();
    return mdu_op_pkg::mdu_op_e'(4'($urandom % 7));
  endfunction

  task automatic issue(input mdu_op_pkg::mdu_op_e op, input int tag);
    valid_i     = 1'b1;
    op_i        = op;
    trans_id_i  = TransIdBits'(tag);
    operand_a_i = pick_operand();
    operand_b_i = pick_operand();
    issued_cnt[tag]++;
    if (mdu_op_pkg::is_div_op(op)) begin
      credits_used++;
    end
  endtask

  // one random slot that is sometimes idle so a held divide can drain
  task automatic drive_random();
    int tag;
    mdu_op_pkg::mdu_op_e op;
    valid_i = 1'b0;
    if ($urandom % 6 == 0) begin
      return;
    end
    if ($urandom % 3 == 0) begin
      op = mdu_op_pkg::mdu_op_e'(4'(7 + $urandom % 4));
    end else begin
      op = pick_mul_op();
    end
    // divides only while a credit is held
    if (mdu_op_pkg::is_div_op(op) && !has_credit()) begin
      return;
    end
    tag = find_free_tag();
    if (tag < 0) begin
      return;
    end
    issue(op, tag);
  endtask

  task automatic wait_for_credit();
    int n;
    n = 0;
    while (!has_credit() && n < WaitLimit) begin
      valid_i = 1'b0;
      next_slot();
      n++;
    end
    if (!has_credit()) begin
      $display("timeout: no divider credit came back within %0d cycles", WaitLimit);
      timeouts++;
    end
  endtask

  // divide with fixed operands once the credit is back
  task automatic issue_div_fixed(input mdu_op_pkg::mdu_op_e op,
                                 input logic [Xlen-1:0] a, input logic [Xlen-1:0] b);
    int tag;
    next_slot();
    valid_i = 1'b0;
    wait_for_credit();
    tag = find_free_tag();
    if (tag >= 0 && has_credit()) begin
      issue(op, tag);
      operand_a_i = a;
      operand_b_i = b;
    end else begin
      $display("no free tag or credit for a directed divide");
      timeouts++;
    end
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------
  initial begin
    int tag;
    int n;
    void'($urandom(89066));
    rst_ni       = 1'b1;
    valid_i      = 1'b0;
    op_i         = mdu_op_pkg::MUL;
    trans_id_i   = '0;
    operand_a_i  = '0;
    operand_b_i  = '0;
    credits_used = 0;
    timeouts     = 0;
    for (int t = 0; t < NumIds; t++) begin
      issued_cnt[t] = 0;
    end
    #1 rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    #DriveDelay rst_ni = 1'b1;

    // mixed random traffic
    for (int i = 0; i < NumOps; i++) begin
      next_slot();
      drive_random();
    end

    // a divide under a steady stream of multiplies
    next_slot();
    valid_i = 1'b0;
    wait_for_credit();
    tag = find_free_tag();
    if (tag >= 0 && has_credit()) begin
      issue(mdu_op_pkg::DIV, tag);
    end
    for (int i = 0; i < Xlen + 8; i++) begin
      next_slot();
      tag = find_free_tag();
      if (tag >= 0) begin
        issue(pick_mul_op(), tag);
      end else begin
        valid_i = 1'b0;
      end
    end
    next_slot();
    valid_i = 1'b0;
    wait_for_credit();

    // signed overflow and zero divisor
    issue_div_fixed(mdu_op_pkg::DIV, MinNeg, '1);
    issue_div_fixed(mdu_op_pkg::REM, MinNeg, '1);
    issue_div_fixed(mdu_op_pkg::DIV, MinNeg, '0);
    issue_div_fixed(mdu_op_pkg::REMU, MinNeg, '0);
    next_slot();
    valid_i = 1'b0;

    // drain everything still in flight
    repeat (2) next_slot();
    n = 0;
    while (chk_pending != 0 && n < WaitLimit) begin
      next_slot();
      n++;
    end
    if (chk_pending != 0) begin
      $display("timeout: %0d operations still outstanding at the end", chk_pending);
      timeouts++;
    end
    repeat (2) next_slot();

    $display("summary: %0d results checked, %0d checker errors, %0d timeouts",
             chk_checked, chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: test/mdu_assertions.sv
`timescale 1ns/100ps

module mdu_assertions #(
  parameter int unsigned Xlen = 32
) (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    result_valid_i,
  input logic                    div_credit_i,
  input mdu_cfg_pkg::div_state_e div_state_i
);

  // consecutive cycles the divider spent in CALC
  int unsigned calc_run;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      calc_run <= '0;
    end else if (div_state_i == mdu_cfg_pkg::CALC) begin
      calc_run <= calc_run + 1;
    end else begin
      calc_run <= '0;
    end
  end

  // quiet outputs during reset
  assert property (@(posedge clk_i) !rst_ni |-> (!result_valid_i && !div_credit_i))
    else $error("result or credit active during reset");

  // and on the first edge after release
  assert property (@(posedge clk_i) $rose(rst_ni) |-> (!result_valid_i && !div_credit_i))
    else $error("result or credit active right after reset");

  // credit pulse rides on a result
  assert property (@(posedge clk_i) disable iff (!rst_ni) div_credit_i |-> result_valid_i)
    else $error("divider credit returned without a result");

  // xlen steps, never more
  assert property (@(posedge clk_i) disable iff (!rst_ni) calc_run <= Xlen)
    else $error("divider stayed in CALC longer than xlen cycles");

endmodule

// File: test/mdu_checker.sv
`timescale 1ns/100ps

module mdu_checker #(
  parameter int unsigned Xlen        = 32,
  parameter int unsigned TransIdBits = 3
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   valid_i,
  input  mdu_op_pkg::mdu_op_e    op_i,
  input  logic [TransIdBits-1:0] trans_id_i,
  input  logic [Xlen-1:0]        operand_a_i,
  input  logic [Xlen-1:0]        operand_b_i,
  input  logic                   result_valid_i,
  input  logic [Xlen-1:0]        result_i,
  input  logic [TransIdBits-1:0] result_trans_id_i,
  input  logic                   div_credit_i,
  output int                     err_count_o,
  output int                     pending_count_o,
  output int                     checked_count_o
);

  localparam int NumIds     = 1 << TransIdBits;
  localparam int StaleLimit = 16 * Xlen;

  // ---------------------------------------------------------------------------
  // reference model
  // ---------------------------------------------------------------------------
  function automatic logic [Xlen-1:0] mul_model(mdu_op_pkg::mdu_op_e op,
                                                logic [Xlen-1:0] a, logic [Xlen-1:0] b);
    logic signed [2*Xlen-1:0] sa, sb;
    logic [2*Xlen-1:0]        ua, ub, p, cl;
    sa = $signed(a);
    sb = $signed(b);
    ua = {{Xlen{1'b0}}, a};
    ub = {{Xlen{1'b0}}, b};
    // full double width products
    case (op)
      mdu_op_pkg::MULH:   p = sa * sb;
      mdu_op_pkg::MULHSU: p = sa * ub;
      default:            p = ua * ub;
    endcase
    // carry-less product uses xor instead of add
    cl = '0;
    for (int i = 0; i < Xlen; i++) begin
      if (b[i]) begin
        cl = cl ^ (ua << i);
      end
    end
    case (op)
      mdu_op_pkg::MUL:    return p[Xlen-1:0];
      mdu_op_pkg::CLMUL:  return cl[Xlen-1:0];
      mdu_op_pkg::CLMULH: return cl[2*Xlen-1:Xlen];
      mdu_op_pkg::CLMULR: return cl[2*Xlen-2:Xlen-1];
      default:            return p[2*Xlen-1:Xlen];
    endcase
  endfunction

  // risc-v rules for zero divisor and signed overflow
  function automatic logic [Xlen-1:0] div_model(mdu_op_pkg::mdu_op_e op,
                                                logic [Xlen-1:0] a, logic [Xlen-1:0] b);
    logic signed [Xlen-1:0] sa, sb, sq, sr;
    logic [Xlen-1:0]        q, r;
    logic                   ovf;
    sa  = a;
    sb  = b;
    ovf = (a == {1'b1, {(Xlen-1){1'b0}}}) && (b == '1);
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (op == mdu_op_pkg::DIVU || op == mdu_op_pkg::REMU) begin
      q = a / b;
      r = a % b;
    end else if (ovf) begin
      q = a;
      r = '0;
    end else begin
      // signed quotient truncates toward zero
      sq = sa / sb;
      sr = sa % sb;
      q  = sq;
      r  = sr;
    end
    return (op == mdu_op_pkg::DIV || op == mdu_op_pkg::DIVU) ? q : r;
  endfunction

  // ---------------------------------------------------------------------------
  // scoreboard by tag
  // ---------------------------------------------------------------------------
  mdu_op_pkg::mdu_op_e exp_op    [NumIds];
  logic [Xlen-1:0]     exp_val   [NumIds];
  int                  issue_cyc [NumIds];
  logic                pending   [NumIds];
  int                  cyc, last_idle;

  always @(negedge clk_i) begin
    int                  tag;
    int                  lat;
    mdu_op_pkg::mdu_op_e op;
    if (!rst_ni) begin
      for (int t = 0; t < NumIds; t++) begin
        pending[t] = 1'b0;
      end
      cyc             = 0;
      last_idle       = -1;
      err_count_o     = 0;
      pending_count_o = 0;
      checked_count_o = 0;
      if (result_valid_i || div_credit_i) begin
        $display("reset error: result or credit active while reset is held");
        err_count_o++;
      end
    end else begin
      tag = int'(result_trans_id_i);
      // a credit belongs to a divide result in the same cycle
      if (div_credit_i && !(result_valid_i && pending[tag] &&
                            mdu_op_pkg::is_div_op(exp_op[tag]))) begin
        $display("credit error: credit pulse at cycle %0d without a divide result", cyc);
        err_count_o++;
      end
      if (result_valid_i && !pending[tag]) begin
        $display("unknown tag: result with tag %0d has no outstanding operation", tag);
        err_count_o++;
      end else if (result_valid_i) begin
        op  = exp_op[tag];
        lat = cyc - issue_cyc[tag];
        checked_count_o++;
        if (result_i !== exp_val[tag]) begin
          $display("ERR %s_tag%0d expected %h actual %h", op.name(), tag, exp_val[tag],
                   result_i);
          err_count_o++;
        end
        if (mdu_op_pkg::is_div_op(op)) begin
          if (!div_credit_i) begin
            $display("credit error: divide tag %0d finished without a credit pulse", tag);
            err_count_o++;
          end
          if (lat < int'(Xlen) + 1) begin
            $display("divide tag %0d finished after %0d cycles, sooner than allowed", tag, lat);
            err_count_o++;
          end else if (lat > int'(Xlen) + 1 && last_idle >= issue_cyc[tag] + int'(Xlen) + 1) begin
            // output had a free slot but the divide stayed put
            $display("divide tag %0d held back although the output was free", tag);
            err_count_o++;
          end
        end else if (lat != 1) begin
          $display("ERR %s_latency_tag%0d expected 1 actual %0d", op.name(), tag, lat);
          err_count_o++;
        end
        pending[tag] = 1'b0;
        pending_count_o--;
      end
      // lost results
      for (int t = 0; t < NumIds; t++) begin
        if (pending[t] && (cyc - issue_cyc[t] > StaleLimit)) begin
          $display("timeout: tag %0d issued at cycle %0d never completed", t, issue_cyc[t]);
          err_count_o++;
          pending[t] = 1'b0;
          pending_count_o--;
        end
      end
      // record the new issue
      if (valid_i) begin
        tag = int'(trans_id_i);
        if (pending[tag]) begin
          $display("issue error: tag %0d reused while still outstanding", tag);
          err_count_o++;
        end else begin
          pending_count_o++;
        end
        exp_op[tag]    = op_i;
        exp_val[tag]   = mdu_op_pkg::is_div_op(op_i) ? div_model(op_i, operand_a_i, operand_b_i)
                                                     : mul_model(op_i, operand_a_i, operand_b_i);
        issue_cyc[tag] = cyc;
        pending[tag]   = 1'b1;
      end
      if (!result_valid_i) begin
        last_idle = cyc;
      end
      cyc++;
    end
  end

endmodule

// File: design/mdu_top.sv
`timescale 1ns/100ps

module mdu_top #(
  parameter int unsigned Xlen        = mdu_cfg_pkg::XLEN_DEFAULT,
  parameter int unsigned TransIdBits = mdu_cfg_pkg::TRANS_ID_BITS_DEFAULT
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // issue side
  input  logic                   valid_i,
  input  mdu_op_pkg::mdu_op_e    op_i,
  input  logic [TransIdBits-1:0] trans_id_i,
  input  logic [Xlen-1:0]        operand_a_i,
  input  logic [Xlen-1:0]        operand_b_i,
  // writeback side
  output logic                   result_valid_o,
  output logic [Xlen-1:0]        result_o,
  output logic [TransIdBits-1:0] result_trans_id_o,
  output logic                   div_credit_o
);

  logic                   is_div, mul_valid, div_start;
  logic                   mul_valid_out;
  logic [Xlen-1:0]        mul_result, div_result;
  logic [TransIdBits-1:0] mul_trans_id, div_trans_id;
  logic                   cnt_load, cnt_en, cnt_done;
  logic                   dp_load, dp_step, div_done, div_taken;

  // issue split between the two units
  assign is_div    = mdu_op_pkg::is_div_op(op_i);
  assign mul_valid = valid_i & ~is_div;
  assign div_start = valid_i & is_div;

  // -------------------------------------------------------------------------
  // units
  // -------------------------------------------------------------------------
  multiplier #(
    .Xlen        (Xlen),
    .TransIdBits (TransIdBits)
  ) i_multiplier (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mult_valid_i    (mul_valid),
    .operation_i     (op_i),
    .trans_id_i      (trans_id_i),
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .result_o        (mul_result),
    .mult_valid_o    (mul_valid_out),
    .mult_trans_id_o (mul_trans_id)
  );

  div_ctrl_fsm i_div_ctrl_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .div_start_i  (div_start),
    .cnt_done_i   (cnt_done),
    .div_taken_i  (div_taken),
    .cnt_load_o   (cnt_load),
    .cnt_en_o     (cnt_en),
    .dp_load_o    (dp_load),
    .dp_step_o    (dp_step),
    .div_done_o   (div_done),
    .div_credit_o (div_credit_o)
  );

  div_step_counter #(
    .Xlen (Xlen)
  ) i_div_step_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load_i (cnt_load),
    .en_i   (cnt_en),
    .done_o (cnt_done)
  );

  div_datapath #(
    .Xlen        (Xlen),
    .TransIdBits (TransIdBits)
  ) i_div_datapath (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (dp_load),
    .step_i      (dp_step),
    .op_i        (op_i),
    .trans_id_i  (trans_id_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (div_result),
    .trans_id_o  (div_trans_id)
  );

  mdu_writeback #(
    .Xlen        (Xlen),
    .TransIdBits (TransIdBits)
  ) i_mdu_writeback (
    .mul_valid_i       (mul_valid_out),
    .mul_result_i      (mul_result),
    .mul_trans_id_i    (mul_trans_id),
    .div_done_i        (div_done),
    .div_result_i      (div_result),
    .div_trans_id_i    (div_trans_id),
    .div_taken_o       (div_taken),
    .result_valid_o    (result_valid_o),
    .result_o          (result_o),
    .result_trans_id_o (result_trans_id_o)
  );

endmodule

// File: design/mdu_writeback.sv
`timescale 1ns/100ps

module mdu_writeback #(
  parameter int unsigned Xlen        = 32,
  parameter int unsigned TransIdBits = 3
) (
  // multiplier stream, never stalls
  input  logic                   mul_valid_i,
  input  logic [Xlen-1:0]        mul_result_i,
  input  logic [TransIdBits-1:0] mul_trans_id_i,
  // divider stream, waits for a free slot
  input  logic                   div_done_i,
  input  logic [Xlen-1:0]        div_result_i,
  input  logic [TransIdBits-1:0] div_trans_id_i,
  output logic                   div_taken_o,
  // register file write port
  output logic                   result_valid_o,
  output logic [Xlen-1:0]        result_o,
  output logic [TransIdBits-1:0] result_trans_id_o
);

  // divider only gets the port when the multiplier is idle
  assign div_taken_o = div_done_i & ~mul_valid_i;

  assign result_valid_o = mul_valid_i | div_done_i;

  // multiplier first
  always_comb begin
    if (mul_valid_i) begin
      result_o          = mul_result_i;
      result_trans_id_o = mul_trans_id_i;
    end else begin
      result_o          = div_result_i;
      result_trans_id_o = div_trans_id_i;
    end
  end

endmodule

// File: design/div_datapath.sv
`timescale 1ns/100ps

module div_datapath #(
  parameter int unsigned Xlen        = 32,
  parameter int unsigned TransIdBits = 3
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   load_i,
  input  logic                   step_i,
  input  mdu_op_pkg::mdu_op_e    op_i,
  input  logic [TransIdBits-1:0] trans_id_i,
  input  logic [Xlen-1:0]        operand_a_i,
  input  logic [Xlen-1:0]        operand_b_i,
  output logic [Xlen-1:0]        result_o,
  output logic [TransIdBits-1:0] trans_id_o
);

  // -------------------------------------------------------------------------
  // operand capture
  // -------------------------------------------------------------------------
  logic                signed_op;
  logic [Xlen-1:0]     abs_a, abs_b;
  mdu_op_pkg::mdu_op_e op_q;
  logic                neg_a_q, neg_q_q, div_zero_q, ovf_q;

  assign signed_op = mdu_op_pkg::is_signed_div_op(op_i);

  // magnitudes of signed operands
  assign abs_a = (signed_op && operand_a_i[Xlen-1]) ? -operand_a_i : operand_a_i;
  assign abs_b = (signed_op && operand_b_i[Xlen-1]) ? -operand_b_i : operand_b_i;

  // result signs and special cases
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q       <= mdu_op_pkg::DIVU;
      neg_a_q    <= 1'b0;
      neg_q_q    <= 1'b0;
      div_zero_q <= 1'b0;
      ovf_q      <= 1'b0;
    end else if (load_i) begin
      op_q       <= op_i;
      neg_a_q    <= signed_op & operand_a_i[Xlen-1];
      neg_q_q    <= signed_op & (operand_a_i[Xlen-1] ^ operand_b_i[Xlen-1]);
      div_zero_q <= (operand_b_i == '0);
      // most negative over minus one
      ovf_q      <= signed_op && (operand_a_i == {1'b1, {(Xlen-1){1'b0}}}) &&
                    (&operand_b_i);
    end
  end

  // -------------------------------------------------------------------------
  // restoring shift-subtract
  // -------------------------------------------------------------------------
  logic [Xlen-1:0]        quot_q, rem_q, divisor_q, dividend_q;
  logic [TransIdBits-1:0] trans_id_q;
  logic [Xlen:0]          shifted, diff;

  // next dividend bit into the partial remainder
  assign shifted = {rem_q, quot_q[Xlen-1]};
  assign diff    = shifted - {1'b0, divisor_q};

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      quot_q     <= abs_a;
      rem_q      <= '0;
      divisor_q  <= abs_b;
      dividend_q <= operand_a_i;
      trans_id_q <= trans_id_i;
    end else if (step_i) begin
      // no borrow, keep the difference
      if (!diff[Xlen]) begin
        rem_q  <= diff[Xlen-1:0];
        quot_q <= {quot_q[Xlen-2:0], 1'b1};
      end else begin
        rem_q  <= shifted[Xlen-1:0];
        quot_q <= {quot_q[Xlen-2:0], 1'b0};
      end
    end
  end

  // -------------------------------------------------------------------------
  // sign fixup and special results
  // -------------------------------------------------------------------------
  logic [Xlen-1:0] quot_res, rem_res;

  assign quot_res = neg_q_q ? -quot_q : quot_q;
  assign rem_res  = neg_a_q ? -rem_q : rem_q;

  always_comb begin
    if (div_zero_q) begin
      // quotient all ones, remainder is the dividend
      result_o = mdu_op_pkg::is_rem_op(op_q) ? dividend_q : '1;
    end else if (ovf_q) begin
      result_o = mdu_op_pkg::is_rem_op(op_q) ? '0 : dividend_q;
    end else begin
      result_o = mdu_op_pkg::is_rem_op(op_q) ? rem_res : quot_res;
    end
  end

  assign trans_id_o = trans_id_q;

endmodule

// File: design/div_step_counter.sv
`timescale 1ns/100ps

module div_step_counter #(
  parameter int unsigned Xlen = 32
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic load_i,
  input  logic en_i,
  output logic done_o
);

  // wide enough to hold xlen-1
  localparam int unsigned CntW = $clog2(Xlen);

  logic [CntW-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= CntW'(Xlen - 1);
    end else if (en_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // zero marks the last of xlen steps
  assign done_o = (cnt_q == '0);

endmodule

// File: design/div_ctrl_fsm.sv
`timescale 1ns/100ps

module div_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic div_start_i,
  input  logic cnt_done_i,
  input  logic div_taken_i,
  output logic cnt_load_o,
  output logic cnt_en_o,
  output logic dp_load_o,
  output logic dp_step_o,
  output logic div_done_o,
  output logic div_credit_o
);

  mdu_cfg_pkg::div_state_e state_q, state_d;

  // -------------------------------------------------------------------------
  // next state and outputs
  // -------------------------------------------------------------------------
  always_comb begin
    state_d      = state_q;
    cnt_load_o   = 1'b0;
    cnt_en_o     = 1'b0;
    dp_load_o    = 1'b0;
    dp_step_o    = 1'b0;
    div_done_o   = 1'b0;
    div_credit_o = 1'b0;
    unique case (state_q)
      mdu_cfg_pkg::IDLE: begin
        // capture operands, arm the counter
        if (div_start_i) begin
          cnt_load_o = 1'b1;
          dp_load_o  = 1'b1;
          state_d    = mdu_cfg_pkg::CALC;
        end
      end
      mdu_cfg_pkg::CALC: begin
        // one shift-subtract per cycle
        cnt_en_o  = 1'b1;
        dp_step_o = 1'b1;
        if (cnt_done_i) begin
          state_d = mdu_cfg_pkg::FINISH;
        end
      end
      mdu_cfg_pkg::FINISH: begin
        // hold until writeback has a free slot
        div_done_o = 1'b1;
        if (div_taken_i) begin
          div_credit_o = 1'b1;
          state_d      = mdu_cfg_pkg::IDLE;
        end
      end
      default: state_d = mdu_cfg_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= mdu_cfg_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: design/multiplier.sv
`timescale 1ns/100ps

module multiplier #(
  parameter int unsigned Xlen        = 32,
  parameter int unsigned TransIdBits = 3
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   mult_valid_i,
  input  mdu_op_pkg::mdu_op_e    operation_i,
  input  logic [TransIdBits-1:0] trans_id_i,
  input  logic [Xlen-1:0]        operand_a_i,
  input  logic [Xlen-1:0]        operand_b_i,
  output logic [Xlen-1:0]        result_o,
  output logic                   mult_valid_o,
  output logic [TransIdBits-1:0] mult_trans_id_o
);

  // -------------------------------------------------------------------------
  // carry-less multiply
  // -------------------------------------------------------------------------
  logic [Xlen-1:0] operand_a_rev, operand_b_rev;
  logic [Xlen-1:0] clmul_a, clmul_b;
  logic [Xlen-1:0] clmul_d, clmulr_d;
  logic            clmul_rev_mode;

  // high and reversed forms work on mirrored operands
  assign clmul_rev_mode = (operation_i == mdu_op_pkg::CLMULH) ||
                          (operation_i == mdu_op_pkg::CLMULR);

  for (genvar i = 0; i < Xlen; i++) begin : gen_rev_in
    assign operand_a_rev[i] = operand_a_i[Xlen-1-i];
    assign operand_b_rev[i] = operand_b_i[Xlen-1-i];
  end

  assign clmul_a = clmul_rev_mode ? operand_a_rev : operand_a_i;
  assign clmul_b = clmul_rev_mode ? operand_b_rev : operand_b_i;

  // xor-accumulate shifted partial products
  always_comb begin
    clmul_d = '0;
    for (int i = 0; i < Xlen; i++) begin
      if (clmul_b[i]) begin
        clmul_d = clmul_d ^ (clmul_a << i);
      end
    end
  end

  // mirror back, gives clmulr directly
  for (genvar i = 0; i < Xlen; i++) begin : gen_rev_out
    assign clmulr_d[i] = clmul_d[Xlen-1-i];
  end

  // -------------------------------------------------------------------------
  // integer multiply
  // -------------------------------------------------------------------------
  logic                   sign_a, sign_b;
  logic [2*Xlen-1:0]      op_a_ext, op_b_ext;
  logic [2*Xlen-1:0]      product_d;

  // sign select per op
  always_comb begin
    sign_a = 1'b0;
    sign_b = 1'b0;
    unique case (operation_i)
      mdu_op_pkg::MULH: begin
        sign_a = 1'b1;
        sign_b = 1'b1;
      end
      mdu_op_pkg::MULHSU: begin
        sign_a = 1'b1;
      end
      default: begin
        sign_a = 1'b0;
        sign_b = 1'b0;
      end
    endcase
  end

  // extend to double width, product taken mod 2^(2*xlen)
  assign op_a_ext  = {{Xlen{operand_a_i[Xlen-1] & sign_a}}, operand_a_i};
  assign op_b_ext  = {{Xlen{operand_b_i[Xlen-1] & sign_b}}, operand_b_i};
  assign product_d = op_a_ext * op_b_ext;

  // -------------------------------------------------------------------------
  // pipeline register
  // -------------------------------------------------------------------------
  logic                   mult_valid_q;
  mdu_op_pkg::mdu_op_e    op_q;
  logic [TransIdBits-1:0] trans_id_q;
  logic [2*Xlen-1:0]      product_q;
  logic [Xlen-1:0]        clmul_q, clmulr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mult_valid_q <= 1'b0;
      op_q         <= mdu_op_pkg::MUL;
    end else begin
      mult_valid_q <= mult_valid_i;
      op_q         <= operation_i;
    end
  end

  // data only captured on an issue
  always_ff @(posedge clk_i) begin
    if (mult_valid_i) begin
      trans_id_q <= trans_id_i;
      product_q  <= product_d;
      clmul_q    <= clmul_d;
      clmulr_q   <= clmulr_d;
    end
  end

  // field select on the registered op
  always_comb begin
    unique case (op_q)
      mdu_op_pkg::MULH,
      mdu_op_pkg::MULHSU,
      mdu_op_pkg::MULHU:  result_o = product_q[2*Xlen-1:Xlen];
      mdu_op_pkg::CLMUL:  result_o = clmul_q;
      mdu_op_pkg::CLMULH: result_o = clmulr_q >> 1;
      mdu_op_pkg::CLMULR: result_o = clmulr_q;
      // MUL, low half
      default:            result_o = product_q[Xlen-1:0];
    endcase
  end

  assign mult_valid_o    = mult_valid_q;
  assign mult_trans_id_o = trans_id_q;

endmodule

// File: design/mdu_cfg_pkg.sv
package mdu_cfg_pkg;

  // operand width, 64 also supported
  localparam int unsigned XLEN_DEFAULT = 32;

  // tag width of the issue and writeback ports
  localparam int unsigned TRANS_ID_BITS_DEFAULT = 3;

  // the divider holds one operation at a time,
  // so upstream owns a single credit after reset
  localparam int unsigned DIV_CREDITS = 1;

  // divider control states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    CALC   = 2'd1,
    FINISH = 2'd2
  } div_state_e;

endpackage

// File: design/mdu_op_pkg.sv
package mdu_op_pkg;

  // operations handled by the unit, 4-bit encoding
  typedef enum logic [3:0] {
    MUL    = 4'd0,
    MULH   = 4'd1,
    MULHSU = 4'd2,
    MULHU  = 4'd3,
    CLMUL  = 4'd4,
    CLMULH = 4'd5,
    CLMULR = 4'd6,
    DIV    = 4'd7,
    DIVU   = 4'd8,
    REM    = 4'd9,
    REMU   = 4'd10
  } mdu_op_e;

  // divider work, everything else goes to the multiplier
  function automatic logic is_div_op(mdu_op_e op);
    return op inside {DIV, DIVU, REM, REMU};
  endfunction

  // remainder flavours pick the partial remainder
  function automatic logic is_rem_op(mdu_op_e op);
    return op inside {REM, REMU};
  endfunction

  // two's complement operands on the divider
  function automatic logic is_signed_div_op(mdu_op_e op);
    return op inside {DIV, REM};
  endfunction

endpackage
